// File: common/es_pkg.sv
/*
 * eye-scan shared definitions
 * GTX DRP register map, field widths, sequencer states and bundles
 */

package es_pkg;

  localparam int DRP_AW     = 12;
  localparam int DRP_DW     = 16;
  localparam int DMA_W      = 32;
  localparam int HOFF_W     = 12;
  localparam int VOFF_W     = 8;
  localparam int PRESCALE_W = 5;
  localparam int MASK_N     = 5;

  // ******************************
  // GTX eye-scan register map
  localparam logic [DRP_AW-1:0] ADDR_CTRL    = 12'h03d;
  localparam logic [DRP_AW-1:0] ADDR_SDATA0  = 12'h036; // sdata1..4 follow
  localparam logic [DRP_AW-1:0] ADDR_QDATA0  = 12'h031; // qdata1..4 follow
  localparam logic [DRP_AW-1:0] ADDR_HOFFSET = 12'h03c;
  localparam logic [DRP_AW-1:0] ADDR_VOFFSET = 12'h03b;
  localparam logic [DRP_AW-1:0] ADDR_STATUS  = 12'h151;
  localparam logic [DRP_AW-1:0] ADDR_SCNT    = 12'h150;
  localparam logic [DRP_AW-1:0] ADDR_ECNT    = 12'h14f;

  localparam logic [3:0] STATUS_DONE = 4'b0101; // measurement finished

  // ******************************
  // sequencer states, one per access step
  typedef enum logic [5:0] {
    ES_IDLE, ES_STATUS, ES_INIT,
    ES_CTRLINIT_READ, ES_CTRLINIT_RRDY, ES_CTRLINIT_WRITE, ES_CTRLINIT_WRDY,
    ES_SDATA_WRITE, ES_SDATA_WRDY,
    ES_QDATA_WRITE, ES_QDATA_WRDY,
    ES_HOFFSET_READ, ES_HOFFSET_RRDY, ES_HOFFSET_WRITE, ES_HOFFSET_WRDY,
    ES_VOFFSET_READ, ES_VOFFSET_RRDY, ES_VOFFSET_WRITE, ES_VOFFSET_WRDY,
    ES_CTRLSTART_READ, ES_CTRLSTART_RRDY, ES_CTRLSTART_WRITE, ES_CTRLSTART_WRDY,
    ES_STATUS_READ, ES_STATUS_RRDY,
    ES_CTRLSTOP_READ, ES_CTRLSTOP_RRDY, ES_CTRLSTOP_WRITE, ES_CTRLSTOP_WRDY,
    ES_SCNT_READ, ES_SCNT_RRDY,
    ES_ECNT_READ, ES_ECNT_RRDY,
    ES_DMA_WRITE, ES_DMA_WAIT, ES_UPDATE
  } es_state_t;

  // ******************************
  // bundles
  typedef struct packed {
    logic                  init;
    logic [PRESCALE_W-1:0] prescale;
    logic [HOFF_W-1:0]     hoffset_min;
    logic [HOFF_W-1:0]     hoffset_max;
    logic [HOFF_W-1:0]     hoffset_step;
    logic [VOFF_W-1:0]     voffset_min; // two's complement
    logic [VOFF_W-1:0]     voffset_max;
    logic [VOFF_W-1:0]     voffset_step;
    logic [DMA_W-1:0]      start_addr;
  } es_cfg_t;

  typedef struct packed {
    logic [MASK_N-1:0][DRP_DW-1:0] sdata;
    logic [MASK_N-1:0][DRP_DW-1:0] qdata;
  } es_masks_t;

  typedef struct packed {
    logic              sel;
    logic              wr;
    logic [DRP_AW-1:0] addr;
    logic [DRP_DW-1:0] wdata;
  } drp_req_t;

  typedef struct packed {
    logic [DRP_DW-1:0] scnt;
    logic [DRP_DW-1:0] ecnt;
  } es_counts_t;

  typedef struct packed {
    logic [HOFF_W-1:0] hoffset;
    logic [VOFF_W-1:0] voffset;
    logic [DMA_W-1:0]  addr;
  } es_point_t;

endpackage

// File: eye_scan/es_sequencer.sv
/*
 * eye-scan sequencer
 * steps through init, per-point offset programming, measurement
 * and readout; one cycle per access, then waits for completion
 */

module es_sequencer (
  input  logic              up_clk,
  input  logic              up_rstn,
  input  logic              start,
  input  logic              stop,
  input  logic              init,
  input  logic              access_done,
  input  logic              status_hit,
  input  logic              eos,
  input  logic              dma_done,
  output es_pkg::es_state_t state,
  output logic [2:0]        mask_idx,
  output logic              sweep_load,
  output logic              sweep_next,
  output logic              status
);

  es_pkg::es_state_t state_next;
  logic              mask_last;

  assign mask_last  = (mask_idx == 3'(es_pkg::MASK_N - 1));
  assign sweep_load = (state == es_pkg::ES_IDLE);
  assign sweep_next = (state == es_pkg::ES_UPDATE);

  // ******************************
  // next state
  always_comb begin
    state_next = state;
    case (state)
      es_pkg::ES_IDLE: begin
        if (start) state_next = es_pkg::ES_STATUS;
      end
      es_pkg::ES_STATUS: state_next = es_pkg::ES_INIT;
      es_pkg::ES_INIT: begin
        state_next = init ? es_pkg::ES_CTRLINIT_READ : es_pkg::ES_HOFFSET_READ;
      end
      es_pkg::ES_CTRLINIT_READ: state_next = es_pkg::ES_CTRLINIT_RRDY;
      es_pkg::ES_CTRLINIT_RRDY: begin
        if (access_done) state_next = es_pkg::ES_CTRLINIT_WRITE;
      end
      es_pkg::ES_CTRLINIT_WRITE: state_next = es_pkg::ES_CTRLINIT_WRDY;
      es_pkg::ES_CTRLINIT_WRDY: begin
        if (access_done) state_next = es_pkg::ES_SDATA_WRITE;
      end
      es_pkg::ES_SDATA_WRITE: state_next = es_pkg::ES_SDATA_WRDY;
      es_pkg::ES_SDATA_WRDY: begin // five sample masks
        if (access_done) begin
          state_next = mask_last ? es_pkg::ES_QDATA_WRITE : es_pkg::ES_SDATA_WRITE;
        end
      end
      es_pkg::ES_QDATA_WRITE: state_next = es_pkg::ES_QDATA_WRDY;
      es_pkg::ES_QDATA_WRDY: begin // five qualifier masks
        if (access_done) begin
          state_next = mask_last ? es_pkg::ES_HOFFSET_READ : es_pkg::ES_QDATA_WRITE;
        end
      end
      es_pkg::ES_HOFFSET_READ: state_next = es_pkg::ES_HOFFSET_RRDY;
      es_pkg::ES_HOFFSET_RRDY: begin
        if (access_done) state_next = es_pkg::ES_HOFFSET_WRITE;
      end
      es_pkg::ES_HOFFSET_WRITE: state_next = es_pkg::ES_HOFFSET_WRDY;
      es_pkg::ES_HOFFSET_WRDY: begin
        if (access_done) state_next = es_pkg::ES_VOFFSET_READ;
      end
      es_pkg::ES_VOFFSET_READ: state_next = es_pkg::ES_VOFFSET_RRDY;
      es_pkg::ES_VOFFSET_RRDY: begin
        if (access_done) state_next = es_pkg::ES_VOFFSET_WRITE;
      end
      es_pkg::ES_VOFFSET_WRITE: state_next = es_pkg::ES_VOFFSET_WRDY;
      es_pkg::ES_VOFFSET_WRDY: begin
        if (access_done) state_next = es_pkg::ES_CTRLSTART_READ;
      end
      es_pkg::ES_CTRLSTART_READ: state_next = es_pkg::ES_CTRLSTART_RRDY;
      es_pkg::ES_CTRLSTART_RRDY: begin
        if (access_done) state_next = es_pkg::ES_CTRLSTART_WRITE;
      end
      es_pkg::ES_CTRLSTART_WRITE: state_next = es_pkg::ES_CTRLSTART_WRDY;
      es_pkg::ES_CTRLSTART_WRDY: begin
        if (access_done) state_next = es_pkg::ES_STATUS_READ;
      end
      es_pkg::ES_STATUS_READ: state_next = es_pkg::ES_STATUS_RRDY;
      es_pkg::ES_STATUS_RRDY: begin // poll until done
        if (access_done) begin
          state_next = status_hit ? es_pkg::ES_CTRLSTOP_READ : es_pkg::ES_STATUS_READ;
        end
      end
      es_pkg::ES_CTRLSTOP_READ: state_next = es_pkg::ES_CTRLSTOP_RRDY;
      es_pkg::ES_CTRLSTOP_RRDY: begin
        if (access_done) state_next = es_pkg::ES_CTRLSTOP_WRITE;
      end
      es_pkg::ES_CTRLSTOP_WRITE: state_next = es_pkg::ES_CTRLSTOP_WRDY;
      es_pkg::ES_CTRLSTOP_WRDY: begin
        if (access_done) state_next = es_pkg::ES_SCNT_READ;
      end
      es_pkg::ES_SCNT_READ: state_next = es_pkg::ES_SCNT_RRDY;
      es_pkg::ES_SCNT_RRDY: begin
        if (access_done) state_next = es_pkg::ES_ECNT_READ;
      end
      es_pkg::ES_ECNT_READ: state_next = es_pkg::ES_ECNT_RRDY;
      es_pkg::ES_ECNT_RRDY: begin
        if (access_done) state_next = es_pkg::ES_DMA_WRITE;
      end
      es_pkg::ES_DMA_WRITE: state_next = es_pkg::ES_DMA_WAIT;
      es_pkg::ES_DMA_WAIT: begin
        if (dma_done) state_next = es_pkg::ES_UPDATE;
      end
      es_pkg::ES_UPDATE: begin // lpm only, always a horizontal step
        state_next = eos ? es_pkg::ES_IDLE : es_pkg::ES_HOFFSET_READ;
      end
      default: state_next = es_pkg::ES_IDLE;
    endcase
  end

  // ******************************
  // state, mask index and status
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      state    <= es_pkg::ES_IDLE;
      mask_idx <= 3'd0;
      status   <= 1'b0;
    end else begin
      state  <= stop ? es_pkg::ES_IDLE : state_next; // stop aborts anywhere
      status <= (state != es_pkg::ES_IDLE);
      if (state == es_pkg::ES_INIT) begin
        mask_idx <= 3'd0;
      end else if (access_done && ((state == es_pkg::ES_SDATA_WRDY) ||
                                   (state == es_pkg::ES_QDATA_WRDY))) begin
        mask_idx <= mask_last ? 3'd0 : mask_idx + 3'd1;
      end
    end
  end

  a_mask_idx_range: assert property (@(posedge up_clk) disable iff (!up_rstn)
    mask_idx <= 3'(es_pkg::MASK_N - 1));

  a_stop_to_idle: assert property (@(posedge up_clk) disable iff (!up_rstn)
    stop |=> (state == es_pkg::ES_IDLE));

endmodule

// File: eye_scan/es_sweep.sv
/*
 * eye-scan offset sweep
 * horizontal inner loop, vertical outer loop, result address per point
 */

module es_sweep (
  input  logic              up_clk,
  input  logic              up_rstn,
  input  es_pkg::es_cfg_t   cfg,
  input  logic              sweep_load,
  input  logic              sweep_next,
  output logic              eos,
  output es_pkg::es_point_t point
);

  logic heos;

  assign heos = (point.hoffset == cfg.hoffset_max);              // end of row
  assign eos  = heos && (point.voffset == cfg.voffset_max);      // last point

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      point <= '0;
    end else if (sweep_load) begin
      point.hoffset <= cfg.hoffset_min;
      point.voffset <= cfg.voffset_min;
      point.addr    <= cfg.start_addr;
    end else if (sweep_next) begin
      point.addr <= point.addr + 32'd4; // one word per point
      if (heos) begin
        point.hoffset <= cfg.hoffset_min;
        point.voffset <= point.voffset + cfg.voffset_step;
      end else begin
        point.hoffset <= point.hoffset + cfg.hoffset_step;
      end
    end
  end

  // only meaningful when the step lands exactly on max
  a_hoffset_in_range: assert property (@(posedge up_clk)
    disable iff (!up_rstn || sweep_load)
    ((cfg.hoffset_step != '0) && (cfg.hoffset_min <= cfg.hoffset_max) &&
     (((cfg.hoffset_max - cfg.hoffset_min) % cfg.hoffset_step) == '0))
    |-> (point.hoffset <= cfg.hoffset_max));

endmodule

// File: eye_scan/es_drp_port.sv
/*
 * eye-scan DRP port
 * turns sequencer states into DRP strobes, captures read data
 * and builds the read-modify-write values
 */

module es_drp_port (
  input  logic                      up_clk,
  input  logic                      up_rstn,
  input  es_pkg::es_state_t         state,
  input  logic [2:0]                mask_idx,
  input  es_pkg::es_cfg_t           cfg,
  input  es_pkg::es_masks_t         masks,
  input  es_pkg::es_point_t         point,
  output es_pkg::drp_req_t          drp,
  input  logic [es_pkg::DRP_DW-1:0] drp_rdata,
  input  logic                      drp_ready,
  output logic                      access_done,
  output logic                      status_hit,
  output es_pkg::es_counts_t        counts
);

  es_pkg::drp_req_t          acc;
  logic                      sel_q;
  logic                      wr_q;
  logic [es_pkg::DRP_AW-1:0] addr_q;
  logic [es_pkg::DRP_DW-1:0] wdata_q;
  logic [es_pkg::DRP_DW-1:0] ctrl_rdata;
  logic [es_pkg::DRP_DW-1:0] hoffset_rdata;
  logic [es_pkg::DRP_DW-1:0] voffset_rdata;
  logic [es_pkg::VOFF_W-1:0] voffset_neg;
  logic [es_pkg::VOFF_W-1:0] voffset_sm;
  logic                      waiting;

  // sign-magnitude vertical offset
  assign voffset_neg = ~point.voffset + 8'd1;
  assign voffset_sm  = point.voffset[7] ? {1'b1, voffset_neg[6:0]} : point.voffset;

  // ******************************
  // state to access decode
  always_comb begin
    acc = '0;
    case (state)
      es_pkg::ES_CTRLINIT_READ, es_pkg::ES_CTRLSTART_READ, es_pkg::ES_CTRLSTOP_READ: begin
        acc.sel  = 1'b1;
        acc.addr = es_pkg::ADDR_CTRL;
      end
      es_pkg::ES_CTRLINIT_WRITE: begin
        acc.sel   = 1'b1;
        acc.wr    = 1'b1;
        acc.addr  = es_pkg::ADDR_CTRL;
        acc.wdata = {ctrl_rdata[15:10], 2'b11, ctrl_rdata[7:0]}; // scan enable
      end
      es_pkg::ES_SDATA_WRITE: begin
        acc.sel   = 1'b1;
        acc.wr    = 1'b1;
        acc.addr  = es_pkg::ADDR_SDATA0 + 12'(mask_idx);
        acc.wdata = masks.sdata[mask_idx];
      end
      es_pkg::ES_QDATA_WRITE: begin
        acc.sel   = 1'b1;
        acc.wr    = 1'b1;
        acc.addr  = es_pkg::ADDR_QDATA0 + 12'(mask_idx);
        acc.wdata = masks.qdata[mask_idx];
      end
      es_pkg::ES_HOFFSET_READ: begin
        acc.sel  = 1'b1;
        acc.addr = es_pkg::ADDR_HOFFSET;
      end
      es_pkg::ES_HOFFSET_WRITE: begin
        acc.sel   = 1'b1;
        acc.wr    = 1'b1;
        acc.addr  = es_pkg::ADDR_HOFFSET;
        acc.wdata = {hoffset_rdata[15:12], point.hoffset};
      end
      es_pkg::ES_VOFFSET_READ: begin
        acc.sel  = 1'b1;
        acc.addr = es_pkg::ADDR_VOFFSET;
      end
      es_pkg::ES_VOFFSET_WRITE: begin
        acc.sel   = 1'b1;
        acc.wr    = 1'b1;
        acc.addr  = es_pkg::ADDR_VOFFSET;
        acc.wdata = {cfg.prescale, voffset_rdata[10:9], 1'b0, voffset_sm}; // ut = 0
      end
      es_pkg::ES_CTRLSTART_WRITE, es_pkg::ES_CTRLSTOP_WRITE: begin
        acc.sel   = 1'b1;
        acc.wr    = 1'b1;
        acc.addr  = es_pkg::ADDR_CTRL;
        acc.wdata = {ctrl_rdata[15:6], (state == es_pkg::ES_CTRLSTART_WRITE) ? 6'd1 : 6'd0};
      end
      es_pkg::ES_STATUS_READ: begin
        acc.sel  = 1'b1;
        acc.addr = es_pkg::ADDR_STATUS;
      end
      es_pkg::ES_SCNT_READ: begin
        acc.sel  = 1'b1;
        acc.addr = es_pkg::ADDR_SCNT;
      end
      es_pkg::ES_ECNT_READ: begin
        acc.sel  = 1'b1;
        acc.addr = es_pkg::ADDR_ECNT;
      end
      default: acc = '0;
    endcase
  end

  always_comb begin
    case (state)
      es_pkg::ES_CTRLINIT_RRDY, es_pkg::ES_CTRLINIT_WRDY, es_pkg::ES_SDATA_WRDY,
      es_pkg::ES_QDATA_WRDY, es_pkg::ES_HOFFSET_RRDY, es_pkg::ES_HOFFSET_WRDY,
      es_pkg::ES_VOFFSET_RRDY, es_pkg::ES_VOFFSET_WRDY, es_pkg::ES_CTRLSTART_RRDY,
      es_pkg::ES_CTRLSTART_WRDY, es_pkg::ES_STATUS_RRDY, es_pkg::ES_CTRLSTOP_RRDY,
      es_pkg::ES_CTRLSTOP_WRDY, es_pkg::ES_SCNT_RRDY, es_pkg::ES_ECNT_RRDY: waiting = 1'b1;
      default: waiting = 1'b0;
    endcase
  end

  assign access_done = waiting && drp_ready;
  assign status_hit  = drp_ready && (drp_rdata[3:0] == es_pkg::STATUS_DONE);

  // ******************************
  // drp request registers
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      sel_q <= 1'b0;
      wr_q  <= 1'b0;
    end else begin
      sel_q <= acc.sel; // one-cycle strobe
      wr_q  <= acc.wr;
    end
  end

  always_ff @(posedge up_clk) begin
    addr_q  <= acc.addr;
    wdata_q <= acc.wdata;
  end

  assign drp = '{sel: sel_q, wr: wr_q, addr: addr_q, wdata: wdata_q};

  // read captures
  always_ff @(posedge up_clk) begin
    if (drp_ready) begin
      case (state)
        es_pkg::ES_CTRLINIT_RRDY, es_pkg::ES_CTRLSTART_RRDY,
        es_pkg::ES_CTRLSTOP_RRDY: ctrl_rdata <= drp_rdata;
        es_pkg::ES_HOFFSET_RRDY:  hoffset_rdata <= drp_rdata;
        es_pkg::ES_VOFFSET_RRDY:  voffset_rdata <= drp_rdata;
        es_pkg::ES_SCNT_RRDY:     counts.scnt <= drp_rdata;
        es_pkg::ES_ECNT_RRDY:     counts.ecnt <= drp_rdata;
        default: ;
      endcase
    end
  end

  a_sel_single_cycle: assert property (@(posedge up_clk) disable iff (!up_rstn)
    drp.sel |=> !drp.sel);

endmodule

// File: eye_scan/es_result_dma.sv
/*
 * eye-scan result DMA
 * posts {scnt, ecnt} for each point, request held until ack
 */

module es_result_dma (
  input  logic                     up_clk,
  input  logic                     up_rstn,
  input  es_pkg::es_state_t        state,
  input  es_pkg::es_point_t        point,
  input  es_pkg::es_counts_t       counts,
  output logic                     dma_req,
  output logic [es_pkg::DMA_W-1:0] dma_addr,
  output logic [es_pkg::DMA_W-1:0] dma_data,
  input  logic                     dma_ack,
  output logic                     dma_done
);

  assign dma_done = dma_req && dma_ack;

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      dma_req <= 1'b0;
    end else if (dma_done) begin
      dma_req <= 1'b0; // drop after ack
    end else if (state == es_pkg::ES_DMA_WRITE) begin
      dma_req <= 1'b1;
    end
  end

  always_ff @(posedge up_clk) begin
    if (state == es_pkg::ES_DMA_WRITE) begin
      dma_addr <= point.addr;
      dma_data <= {counts.scnt, counts.ecnt};
    end
  end

  a_dma_hold: assert property (@(posedge up_clk) disable iff (!up_rstn)
    (dma_req && !dma_ack) |=> (dma_req && $stable(dma_addr) && $stable(dma_data)));

endmodule

// File: eye_scan/gt_eye_scan.sv
/*
 * gt eye-scan engine, GTX register map
 * sweeps a grid of horizontal and vertical offsets over DRP
 * and posts sample and error counts per point over DMA
 */

module gt_eye_scan (
  input  logic                        up_clk,
  input  logic                        up_rstn,

  // processor side
  input  logic                        start,
  input  logic                        stop,
  input  es_pkg::es_cfg_t             cfg,
  input  es_pkg::es_masks_t           masks,
  output logic                        status,

  // drp master
  output es_pkg::drp_req_t            drp,
  input  logic [es_pkg::DRP_DW-1:0]   drp_rdata,
  input  logic                        drp_ready,

  // dma master
  output logic                        dma_req,
  output logic [es_pkg::DMA_W-1:0]    dma_addr,
  output logic [es_pkg::DMA_W-1:0]    dma_data,
  input  logic                        dma_ack
);

  es_pkg::es_state_t  state;
  es_pkg::es_point_t  point;
  es_pkg::es_counts_t counts;
  logic [2:0]         mask_idx;
  logic               sweep_load;
  logic               sweep_next;
  logic               access_done;
  logic               status_hit;
  logic               eos;
  logic               dma_done;

  es_sequencer u_sequencer (
    .up_clk      (up_clk),
    .up_rstn     (up_rstn),
    .start       (start),
    .stop        (stop),
    .init        (cfg.init),
    .access_done (access_done),
    .status_hit  (status_hit),
    .eos         (eos),
    .dma_done    (dma_done),
    .state       (state),
    .mask_idx    (mask_idx),
    .sweep_load  (sweep_load),
    .sweep_next  (sweep_next),
    .status      (status)
  );

  es_sweep u_sweep (
    .up_clk     (up_clk),
    .up_rstn    (up_rstn),
    .cfg        (cfg),
    .sweep_load (sweep_load),
    .sweep_next (sweep_next),
    .eos        (eos),
    .point      (point)
  );

  es_drp_port u_drp_port (
    .up_clk      (up_clk),
    .up_rstn     (up_rstn),
    .state       (state),
    .mask_idx    (mask_idx),
    .cfg         (cfg),
    .masks       (masks),
    .point       (point),
    .drp         (drp),
    .drp_rdata   (drp_rdata),
    .drp_ready   (drp_ready),
    .access_done (access_done),
    .status_hit  (status_hit),
    .counts      (counts)
  );

  es_result_dma u_result_dma (
    .up_clk   (up_clk),
    .up_rstn  (up_rstn),
    .state    (state),
    .point    (point),
    .counts   (counts),
    .dma_req  (dma_req),
    .dma_addr (dma_addr),
    .dma_data (dma_data),
    .dma_ack  (dma_ack),
    .dma_done (dma_done)
  );

endmodule

// File: dv/tb_gt_eye_scan.sv
/*
 * testbench for the gt eye-scan engine
 * DRP register model, DMA responder, a full scan with init
 * and a second scan aborted part way
 */

module tb_gt_eye_scan;

  logic                      up_clk = 1'b0;
  logic                      up_rstn;
  logic                      start;
  logic                      stop;
  es_pkg::es_cfg_t           cfg;
  es_pkg::es_masks_t         masks;
  logic                      status;
  es_pkg::drp_req_t          drp;
  logic [es_pkg::DRP_DW-1:0] drp_rdata = '0;
  logic                      drp_ready = 1'b0;
  logic                      dma_req;
  logic [es_pkg::DMA_W-1:0]  dma_addr;
  logic [es_pkg::DMA_W-1:0]  dma_data;
  logic                      dma_ack = 1'b0;

  integer           seed = 32'hcbd1e74b;
  logic [15:0]      regs [0:4095];  // drp register model
  es_pkg::drp_req_t drp_cur;        // access in flight
  logic             drp_busy = 1'b0;
  int               drp_wait = 0;
  int               poll_cnt = 0;
  int               point_k = 0;    // grid point being measured
  int               init_wr_cnt = 0;
  logic             ack_busy = 1'b0;
  int               ack_wait = 0;
  int               dma_words = 0;
  logic             quiet;          // no bus activity allowed

  logic [11:0] exp_init_addr;
  logic [15:0] exp_init_wdata;
  logic [15:0] exp_hoff_wdata;
  logic [15:0] exp_voff_wdata;
  logic [31:0] exp_dma_addr;
  logic [31:0] exp_dma_data;

  always #50 up_clk = ~up_clk;

  gt_eye_scan dut0 (
    .up_clk    (up_clk),
    .up_rstn   (up_rstn),
    .start     (start),
    .stop      (stop),
    .cfg       (cfg),
    .masks     (masks),
    .status    (status),
    .drp       (drp),
    .drp_rdata (drp_rdata),
    .drp_ready (drp_ready),
    .dma_req   (dma_req),
    .dma_addr  (dma_addr),
    .dma_data  (dma_data),
    .dma_ack   (dma_ack)
  );

  // ******************************
  // reference model of the grid
  function automatic logic [15:0] fill_value(input logic [11:0] a);
    return 16'hc35a ^ {a, a[11:8]} ^ {a[3:0], a};
  endfunction

  function automatic int h_points(input es_pkg::es_cfg_t c);
    return int'((c.hoffset_max - c.hoffset_min) / c.hoffset_step) + 1;
  endfunction

  function automatic int v_points(input es_pkg::es_cfg_t c);
    int vmin;
    int vmax;
    vmin = int'($signed(c.voffset_min));
    vmax = int'($signed(c.voffset_max));
    return (vmax - vmin) / int'(c.voffset_step) + 1;
  endfunction

  function automatic logic [11:0] point_h(input es_pkg::es_cfg_t c, input int k);
    return c.hoffset_min + 12'((k % h_points(c)) * int'(c.hoffset_step));
  endfunction

  function automatic int point_v(input es_pkg::es_cfg_t c, input int k);
    return int'($signed(c.voffset_min)) + (k / h_points(c)) * int'(c.voffset_step);
  endfunction

  function automatic logic [7:0] sign_mag(input int v);
    if (v < 0) begin
      return {1'b1, 7'(-v)};
    end
    return 8'(v);
  endfunction

  always_comb begin
    exp_init_addr  = es_pkg::ADDR_CTRL;
    exp_init_wdata = fill_value(es_pkg::ADDR_CTRL) | 16'h0300; // scan enable bits
    if (init_wr_cnt >= 1 && init_wr_cnt <= es_pkg::MASK_N) begin
      exp_init_addr  = es_pkg::ADDR_SDATA0 + 12'(init_wr_cnt - 1);
      exp_init_wdata = masks.sdata[init_wr_cnt - 1];
    end else if (init_wr_cnt > es_pkg::MASK_N) begin
      exp_init_addr  = es_pkg::ADDR_QDATA0 + 12'(init_wr_cnt - 1 - es_pkg::MASK_N);
      exp_init_wdata = masks.qdata[init_wr_cnt - 1 - es_pkg::MASK_N];
    end
  end

  assign exp_hoff_wdata = {regs[es_pkg::ADDR_HOFFSET][15:12], point_h(cfg, point_k)};
  assign exp_voff_wdata = {cfg.prescale, regs[es_pkg::ADDR_VOFFSET][10:9], 1'b0,
                           sign_mag(point_v(cfg, point_k))};
  assign exp_dma_addr   = cfg.start_addr + 32'(4 * dma_words);
  assign exp_dma_data   = {16'(dma_words), 16'(dma_words) ^ 16'h00ff};

  // ******************************
  // failure reporting
  task automatic show_mismatch(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    $display("error %s expected %h actual %h", name, exp, act);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic timeout_abort(input string what);
    report_failure({"timed out waiting for ", what});
  endtask

  // ******************************
  // drp slave and dma responder
  initial begin
    for (int a = 0; a < 4096; a++) begin
      regs[a] = fill_value(12'(a));
    end
  end

  always @(negedge up_clk) begin
    drp_ready <= 1'b0;
    if (!up_rstn || start) begin // fresh scan
      drp_busy    = 1'b0;
      ack_busy    = 1'b0;
      poll_cnt    = 0;
      point_k     = 0;
      init_wr_cnt = 0;
      dma_words   = 0;
      dma_ack     <= 1'b0;
    end else begin
      if (drp.sel) begin
        drp_cur  = drp;
        drp_wait = 1 + ($unsigned($random(seed)) % 4);
        drp_busy = 1'b1;
      end else if (drp_busy) begin
        drp_wait--;
        if (drp_wait == 0) begin
          drp_busy = 1'b0;
          drp_ready <= 1'b1;
          if (drp_cur.wr) begin
            regs[drp_cur.addr] = drp_cur.wdata;
            init_wr_cnt++; // completed writes
          end else begin
            case (drp_cur.addr)
              es_pkg::ADDR_STATUS: begin
                poll_cnt++;
                drp_rdata <= (poll_cnt == 3) ? 16'h0005 : 16'h0001; // done on third poll
                if (poll_cnt == 3) poll_cnt = 0;
              end
              es_pkg::ADDR_SCNT: drp_rdata <= 16'(point_k);
              es_pkg::ADDR_ECNT: begin
                drp_rdata <= 16'(point_k) ^ 16'h00ff;
                point_k++;
              end
              default: drp_rdata <= regs[drp_cur.addr];
            endcase
          end
        end
      end
      if (dma_ack) begin // word taken on the last edge
        dma_ack <= 1'b0;
        dma_words++;
      end else if (dma_req) begin
        if (!ack_busy) begin
          ack_wait = $unsigned($random(seed)) % 6;
          ack_busy = 1'b1;
        end
        if (ack_wait == 0) begin
          dma_ack  <= 1'b1;
          ack_busy = 1'b0;
        end else begin
          ack_wait--;
        end
      end
    end
  end

  // ******************************
  // checks
  a_reset_quiet: assert property (@(posedge up_clk)
    !up_rstn |=> (!drp.sel && !dma_req && !status))
    else show_mismatch("reset", 32'd0,
                       {29'd0, $sampled(drp.sel), $sampled(dma_req), $sampled(status)});

  a_init_write: assert property (@(posedge up_clk) disable iff (!up_rstn)
    (drp.sel && drp.wr && cfg.init && init_wr_cnt <= 2 * es_pkg::MASK_N)
    |-> (drp.addr == exp_init_addr && drp.wdata == exp_init_wdata))
    else show_mismatch("init write", {4'd0, $sampled(exp_init_addr), $sampled(exp_init_wdata)},
                       {4'd0, $sampled(drp.addr), $sampled(drp.wdata)});

  a_hoffset_write: assert property (@(posedge up_clk) disable iff (!up_rstn)
    (drp.sel && drp.wr && drp.addr == es_pkg::ADDR_HOFFSET) |-> (drp.wdata == exp_hoff_wdata))
    else show_mismatch("hoffset write", 32'($sampled(exp_hoff_wdata)), 32'($sampled(drp.wdata)));

  a_voffset_write: assert property (@(posedge up_clk) disable iff (!up_rstn)
    (drp.sel && drp.wr && drp.addr == es_pkg::ADDR_VOFFSET) |-> (drp.wdata == exp_voff_wdata))
    else show_mismatch("voffset write", 32'($sampled(exp_voff_wdata)), 32'($sampled(drp.wdata)));

  a_dma_addr: assert property (@(posedge up_clk) disable iff (!up_rstn)
    dma_req |-> (dma_addr == exp_dma_addr))
    else show_mismatch("dma address", $sampled(exp_dma_addr), $sampled(dma_addr));

  a_dma_data: assert property (@(posedge up_clk) disable iff (!up_rstn)
    dma_req |-> (dma_data == exp_dma_data))
    else show_mismatch("dma data", $sampled(exp_dma_data), $sampled(dma_data));

  a_dma_hold: assert property (@(posedge up_clk) disable iff (!up_rstn)
    (dma_req && !dma_ack) |=> (dma_req && $stable(dma_addr) && $stable(dma_data)))
    else report_failure("dma request dropped or changed before ack");

  a_abort_status: assert property (@(posedge up_clk) disable iff (!up_rstn)
    stop |=> ##1 !status)
    else show_mismatch("abort status", 32'd0, {31'd0, $sampled(status)});

  a_idle_bus: assert property (@(posedge up_clk) disable iff (!up_rstn)
    quiet |-> (!drp.sel && !dma_req))
    else show_mismatch("idle bus", 32'd0, {30'd0, $sampled(drp.sel), $sampled(dma_req)});

  // ******************************
  // stimulus
  task automatic load_grid(input logic ini, input logic [11:0] hmin, input logic [11:0] hmax,
                           input logic [11:0] hstep, input logic [7:0] vmin,
                           input logic [7:0] vmax, input logic [7:0] vstep,
                           input logic [31:0] base);
    @(negedge up_clk);
    cfg <= '{init: ini, prescale: 5'd3, hoffset_min: hmin, hoffset_max: hmax,
             hoffset_step: hstep, voffset_min: vmin, voffset_max: vmax,
             voffset_step: vstep, start_addr: base};
  endtask

  task automatic start_scan;
    @(negedge up_clk);
    start <= 1'b1;
    @(negedge up_clk);
    start <= 1'b0;
  endtask

  task automatic abort_scan;
    @(negedge up_clk);
    stop <= 1'b1;
    @(negedge up_clk);
    stop <= 1'b0;
  endtask

  task automatic wait_status(input logic level, input int limit, input string what);
    int n;
    n = 0;
    while (status !== level) begin
      @(negedge up_clk);
      n++;
      if (n > limit) timeout_abort(what);
    end
  endtask

  task automatic wait_words(input int count, input int limit);
    int n;
    n = 0;
    while (dma_words < count) begin
      @(posedge up_clk);
      n++;
      if (n > limit) timeout_abort("dma words");
    end
  endtask

  initial begin
    up_rstn = 1'b0;
    start   = 1'b0;
    stop    = 1'b0;
    quiet   = 1'b0;
    cfg     = '0;
    for (int i = 0; i < es_pkg::MASK_N; i++) begin
      masks.sdata[i] = 16'h5d00 + 16'(i * 16'h0111);
      masks.qdata[i] = 16'h9a00 ^ 16'(i * 16'h0123);
    end
    repeat (8) @(negedge up_clk);
    up_rstn <= 1'b1;

    // full scan with init, vertical -4..4
    load_grid(1'b1, 12'h020, 12'h040, 12'h010, 8'hfc, 8'h04, 8'h04, 32'h0001_0000);
    start_scan();
    wait_status(1'b1, 10, "status to rise");
    wait_status(1'b0, 20000, "end of scan");
    assert (dma_words == h_points(cfg) * v_points(cfg))
      else show_mismatch("word count", 32'(h_points(cfg) * v_points(cfg)), 32'(dma_words));
    quiet <= 1'b1;
    repeat (20) @(negedge up_clk);
    quiet <= 1'b0;

    // second scan, stopped after two points
    load_grid(1'b0, 12'h000, 12'h003, 12'h001, 8'hfe, 8'h02, 8'h02, 32'h0002_0100);
    start_scan();
    wait_status(1'b1, 10, "status to rise");
    wait_words(2, 5000);
    repeat (3) @(negedge up_clk);
    abort_scan();
    repeat (2) @(negedge up_clk);
    quiet <= 1'b1;
    repeat (30) @(negedge up_clk);
    assert (status == 1'b0)
      else show_mismatch("status after stop", 32'd0, {31'd0, status});

    $display("TEST OK");
    $finish;
  end

endmodule

// File: compile.f
common/es_pkg.sv
eye_scan/es_sequencer.sv
eye_scan/es_sweep.sv
eye_scan/es_drp_port.sv
eye_scan/es_result_dma.sv
eye_scan/gt_eye_scan.sv
dv/tb_gt_eye_scan.sv

// File: Bender.yml
package:
  name: gt_eye_scan

sources:
  - files:
      - common/es_pkg.sv
      - eye_scan/es_sequencer.sv
      - eye_scan/es_sweep.sv
      - eye_scan/es_drp_port.sv
      - eye_scan/es_result_dma.sv
      - eye_scan/gt_eye_scan.sv
  - target: test
    files:
      - dv/tb_gt_eye_scan.sv
